// ==== hw/spk_pack_cfg.svh ====
// Channel packer configuration
`ifndef SPK_PACK_CFG_SVH
`define SPK_PACK_CFG_SVH

//////////////////////////////////////////////////////////////////////////////
// store geometry

`define SPK_NUM_CH     160  // channels per frame
`define SPK_NUM_NN     4    // neighbors per group, one wave lane each

// output queue
`define SPK_FIFO_DEPTH 16   // power of two, at least 2

//////////////////////////////////////////////////////////////////////////////
// field widths

`define SPK_CH_W       12   // channel index
`define SPK_ID_W       8    // one neighbor id inside a group word
`define SPK_SAMPLE_W   32   // signed voltage
`define SPK_FRAME_W    32   // frame counter

`endif

// ==== hw/spk_pack_pkg.sv ====
// Channel packer types
`default_nettype none

`include "spk_pack_cfg.svh"

package spk_pack_pkg;

  //////////////////////////////////////////////////////////////////////////
  // sample side

  // running frame number, bit 0 picks the bank
  typedef logic [`SPK_FRAME_W-1:0] frame_t;

  typedef logic [`SPK_CH_W-1:0] ch_t;  // channel index as it arrives

  // one neighbor id
  typedef logic [`SPK_ID_W-1:0] nn_id_t;

  // packed neighbor ids, id n at bits n*ID_W, so neighbor 3 on top
  typedef logic [`SPK_NUM_NN*`SPK_ID_W-1:0] ch_group_t;

  typedef logic signed [`SPK_SAMPLE_W-1:0] sample_t;  // voltage

  //////////////////////////////////////////////////////////////////////////
  // record side

  // gathered neighbor values, neighbor 0 in the top word
  typedef logic [`SPK_NUM_NN*`SPK_SAMPLE_W-1:0] wave_t;

  // frame parity, selects one of the two banks
  typedef logic bank_sel_t;

endpackage

`default_nettype wire

// ==== hw/spk_pack_ifs.sv ====
// Internal sample and record buses
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////////////
// aligned sample, no handshake

interface sample_if
  import spk_pack_pkg::*;
();

  logic      valid;  // sample taken on every cycle this is high
  frame_t    frame;
  ch_t       ch;
  ch_group_t group;  // four neighbor ids
  sample_t   value;

  modport src (
    output valid, frame, ch, group, value
  );

  modport dst (
    input  valid, frame, ch, group, value
  );

endinterface

//////////////////////////////////////////////////////////////////////////////
// bundled record, push only

interface record_if
  import spk_pack_pkg::*;
();

  logic   push;     // one record per cycle at most
  ch_t    ch;       // channel of the sample itself
  ch_t    last_ch;  // id 3 of the group, zero extended
  frame_t frame;
  wave_t  wave;     // neighbor values from the previous frame

  modport src (
    output push, ch, last_ch, frame, wave
  );

  modport dst (
    input  push, ch, last_ch, frame, wave
  );

endinterface

`default_nettype wire

// ==== hw/sample_input_pipe.sv ====
// Sample input register stages
`timescale 1ns/1ps
`default_nettype none

module sample_input_pipe
  import spk_pack_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  frame_t    in_frame,
  input  ch_t       in_ch,
  input  ch_group_t in_group,
  input  sample_t   in_value,
  sample_if.src     sink
);

  // stage 1
  logic      s1_valid;
  frame_t    s1_frame;
  ch_t       s1_ch;
  ch_group_t s1_group;
  sample_t   s1_value;

  // valid bits of both stages
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid   <= 1'b0;
      sink.valid <= 1'b0;
    end else begin
      s1_valid   <= in_valid;
      sink.valid <= s1_valid;  // stage 2 drives the bus directly
    end
  end

  // sample fields, two deep
  always_ff @(posedge clk) begin
    s1_frame   <= in_frame;
    s1_ch      <= in_ch;     // full width, store trims it later
    s1_group   <= in_group;
    s1_value   <= in_value;
    sink.frame <= s1_frame;
    sink.ch    <= s1_ch;
    sink.group <= s1_group;
    sink.value <= s1_value;
  end

endmodule

`default_nettype wire

// ==== hw/frame_bank_buffer.sv ====
// Ping-pong frame store and neighbor gather
`timescale 1ns/1ps
`default_nettype none

`include "spk_pack_cfg.svh"

module frame_bank_buffer
  import spk_pack_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  sample_if.dst smp,
  record_if.src rec
);

  localparam int idx_w = $clog2(`SPK_NUM_CH);

  //////////////////////////////////////////////////////////////////////////
  // storage

  sample_t bank_mem [0:1][0:`SPK_NUM_CH-1];     // [parity][channel]
  logic [1:0][`SPK_NUM_CH-1:0] written;         // entry written since reset

  bank_sel_t        wr_bank;
  bank_sel_t        rd_bank;
  logic [idx_w-1:0] wr_idx;
  logic             wr_ok;

  assign wr_bank = smp.frame[0];   // current frame parity
  assign rd_bank = ~wr_bank;       // previous frame lives here
  assign wr_idx  = smp.ch[idx_w-1:0];
  // trimmed index must still land inside the store
  assign wr_ok   = smp.valid && (wr_idx < `SPK_NUM_CH);

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      bank_mem[wr_bank][wr_idx] <= smp.value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      written <= '0;                        // all entries read as zero
    end else if (wr_ok) begin
      written[wr_bank][wr_idx] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // neighbor gather from the opposite bank

  nn_id_t  nn_id [`SPK_NUM_NN];
  sample_t lane  [`SPK_NUM_NN];
  wave_t   wave_next;

  always_comb begin
    wave_next = '0;
    for (int n = 0; n < `SPK_NUM_NN; n++) begin
      nn_id[n] = smp.group[n*`SPK_ID_W +: `SPK_ID_W];
      // out of range id or never written entry gives zero
      if ((nn_id[n] < `SPK_NUM_CH) && written[rd_bank][nn_id[n]]) begin
        lane[n] = bank_mem[rd_bank][nn_id[n]];
      end else begin
        lane[n] = '0;
      end
      // lane 0 ends up in the top word
      wave_next[(`SPK_NUM_NN-1-n)*`SPK_SAMPLE_W +: `SPK_SAMPLE_W] = lane[n];
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // record bundle, captured in the write edge and pushed one edge later

  always_ff @(posedge clk) begin
    if (rst) begin
      rec.push <= 1'b0;
    end else begin
      rec.push <= smp.valid;   // every valid sample makes a record
    end
  end

  always_ff @(posedge clk) begin
    if (smp.valid) begin
      rec.ch      <= smp.ch;
      rec.last_ch <= {{(`SPK_CH_W-`SPK_ID_W){1'b0}}, nn_id[`SPK_NUM_NN-1]};
      rec.frame   <= smp.frame;
      rec.wave    <= wave_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/record_fifo.sv ====
// Record queue with valid/ready output
`timescale 1ns/1ps
`default_nettype none

`include "spk_pack_cfg.svh"

module record_fifo
  import spk_pack_pkg::*;
#(
  parameter int depth = `SPK_FIFO_DEPTH
) (
  input  logic   clk,
  input  logic   rst,
  record_if.dst  rec,
  output logic   out_valid,
  input  logic   out_ready,
  output ch_t    out_ch,
  output ch_t    out_last_ch,
  output frame_t out_frame,
  output wave_t  out_wave,
  output logic   overflow
);

  localparam int ptr_w = $clog2(depth);
  localparam logic [ptr_w:0] full_cnt = depth[ptr_w:0];

  // entry storage, one array per field
  ch_t    ch_mem      [depth];
  ch_t    last_ch_mem [depth];
  frame_t frame_mem   [depth];
  wave_t  wave_mem    [depth];

  logic [ptr_w-1:0] wr_ptr;   // wraps on its own, depth is a power of two
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == full_cnt);
  assign do_pop  = out_valid && out_ready;
  assign do_push = rec.push && (!full || do_pop);  // pop frees a slot

  always_ff @(posedge clk) begin
    if (do_push) begin
      ch_mem[wr_ptr]      <= rec.ch;
      last_ch_mem[wr_ptr] <= rec.last_ch;
      frame_mem[wr_ptr]   <= rec.frame;
      wave_mem[wr_ptr]    <= rec.wave;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // pointers, count, sticky overflow

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // both or neither
      endcase
      if (rec.push && !do_push) overflow <= 1'b1;   // record lost
    end
  end

  // head entry shown straight from storage
  assign out_valid   = (count != '0);
  assign out_ch      = ch_mem[rd_ptr];
  assign out_last_ch = last_ch_mem[rd_ptr];
  assign out_frame   = frame_mem[rd_ptr];
  assign out_wave    = wave_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== hw/spk_pack_top.sv ====
// Channel packer top level
`timescale 1ns/1ps
`default_nettype none

`include "spk_pack_cfg.svh"

module spk_pack_top
  import spk_pack_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // sample stream in
  input  logic      in_valid,
  input  frame_t    in_frame,
  input  ch_t       in_ch,
  input  ch_group_t in_group,
  input  sample_t   in_value,
  // record stream out
  output logic      out_valid,
  input  logic      out_ready,
  output ch_t       out_ch,
  output ch_t       out_last_ch,
  output frame_t    out_frame,
  output wave_t     out_wave,
  output logic      overflow     // sticky until reset
);

  //////////////////////////////////////////////////////////////////////////
  // internal buses

  sample_if smp_bus ();   // pipe to store
  record_if rec_bus ();   // store to queue

  //////////////////////////////////////////////////////////////////////////
  // blocks

  sample_input_pipe u_sample_input_pipe (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_frame (in_frame),
    .in_ch    (in_ch),
    .in_group (in_group),
    .in_value (in_value),
    .sink     (smp_bus.src)
  );

  frame_bank_buffer u_frame_bank_buffer (
    .clk (clk),
    .rst (rst),
    .smp (smp_bus.dst),
    .rec (rec_bus.src)
  );

  record_fifo #(
    .depth (`SPK_FIFO_DEPTH)
  ) u_record_fifo (
    .clk         (clk),
    .rst         (rst),
    .rec         (rec_bus.dst),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_ch      (out_ch),
    .out_last_ch (out_last_ch),
    .out_frame   (out_frame),
    .out_wave    (out_wave),
    .overflow    (overflow)
  );

endmodule

`default_nettype wire

// ==== tb/clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;               // released between edges
  end

endmodule

`default_nettype wire

// ==== tb/spk_pack_asserts.sv ====
// Output handshake assertions
`timescale 1ns/1ps
`default_nettype none

module spk_pack_asserts
  import spk_pack_pkg::*;
(
  input logic   clk,
  input logic   rst,
  input logic   out_valid,
  input logic   out_ready,
  input ch_t    out_ch,
  input ch_t    out_last_ch,
  input frame_t out_frame,
  input wave_t  out_wave,
  input logic   overflow
);

  // stalled head record must not move
  hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_ch) &&
      $stable(out_last_ch) && $stable(out_frame) && $stable(out_wave)))
    else $error("output record changed while stalled");

  // queue empties on a reset edge
  idle_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high during reset");

  // sticky flag
  overflow_sticky: assert property (@(posedge clk) disable iff (rst)
    overflow |=> overflow)
    else $error("overflow fell without reset");

endmodule

bind spk_pack_top spk_pack_asserts u_spk_pack_asserts (.*);

`default_nettype wire

// ==== tb/spk_pack_tb.sv ====
// Channel packer testbench
`timescale 1ns/1ps
`default_nettype none

module spk_pack_tb
  import spk_pack_pkg::*;
();

  logic clk, rst;
  logic in_valid, out_valid, out_ready, overflow;
  frame_t in_frame, out_frame;
  ch_t in_ch, out_ch, out_last_ch;
  ch_group_t in_group;
  sample_t in_value;
  wave_t out_wave;

  ch_t exp_ch[$];     // expected records, one queue per field
  ch_t exp_last[$];
  frame_t exp_frame[$];
  wave_t exp_wave[$];

  logic [1:0] ready_mode;   // 0 free, 1 random, 2 held low
  logic measure;            // time the next sample

  clk_gen u_clk_gen (.clk(clk), .rst(rst));

  spk_pack_top u_spk_pack_top (.*);

  ////////////////////////////////////////////////////////////////////////////
  // reporting

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_ch(input string name, input ch_t e, input ch_t a);
    if (e !== a) begin
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, e, a);
      fail_now("channel mismatch");
    end
  endtask

  task automatic check_frame(input string name, input frame_t e, input frame_t a);
    if (e !== a) begin
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, e, a);
      fail_now("frame mismatch");
    end
  endtask

  task automatic check_wave(input string name, input wave_t e, input wave_t a);
    if (e !== a) begin
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, e, a);
      fail_now("wave mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic e, input logic a);
    if (e !== a) begin
      $display("ERR t=%0t %s exp=%b act=%b", $time, name, e, a);
      fail_now("flag mismatch");
    end
  endtask

  task automatic check_count(input string name, input int e, input int a);
    if (e != a) begin
      $display("ERR t=%0t %s exp=%0d act=%0d", $time, name, e, a);
      fail_now("latency mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // counts rising edges until the timed record shows up
  task automatic time_latency();
    int cnt;
    cnt = 0;
    while (!out_valid) begin   // one negedge per rising edge passed
      @(negedge clk);
      cnt++;
      if (cnt > 20) fail_now("out_valid never rose after the timed sample");
    end
    check_count("latency_edges", 4, cnt);   // edges k..k+3
  endtask

  task automatic drive_sample(input frame_t f, input ch_t c, input ch_group_t g,
                              input sample_t v, input int gap);
    @(negedge clk);
    in_valid = 1'b1;
    in_frame = f;
    in_ch    = c;
    in_group = g;
    in_value = v;
    if (measure) begin
      measure = 1'b0;
      fork
        time_latency();   // runs beside the gap, expected record comes next
      join_none
    end
    repeat (gap) idle_cycle();
  endtask

  task automatic push_expected(input ch_t c, input ch_t l, input frame_t f,
                               input wave_t w);
    exp_ch.push_back(c);
    exp_last.push_back(l);
    exp_frame.push_back(f);
    exp_wave.push_back(w);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_ch.size() != 0) begin
      @(negedge clk);
      cnt++;
      if (cnt > 500) fail_now("timed out waiting for expected records");
    end
  endtask

  task automatic wait_overflow(input logic lvl);
    int cnt;
    cnt = 0;
    while (overflow !== lvl) begin
      @(negedge clk);
      cnt++;
      if (cnt > 100) fail_now("overflow flag never reached the expected level");
    end
    if (lvl) repeat (3) idle_cycle();   // rest of the burst still in flight
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // consumer, decides ready and checks each accepted record

  initial begin
    logic last_ready;
    void'($urandom(76));
    out_ready = 1'b0;
    last_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (rst) begin
        out_ready = 1'b0;
      end else begin
        case (ready_mode)
          2'd1: out_ready = last_ready ? 1'($urandom % 2) : 1'b1;  // no two lows
          2'd2: out_ready = 1'b0;
          default: out_ready = 1'b1;
        endcase
        last_ready = out_ready;
        if (out_valid && out_ready) begin   // transfer at next rising edge
          if (exp_ch.size() == 0) fail_now("record arrived with none expected");
          check_ch("out_ch", exp_ch.pop_front(), out_ch);
          check_ch("out_last_ch", exp_last.pop_front(), out_last_ch);
          check_frame("out_frame", exp_frame.pop_front(), out_frame);
          check_wave("out_wave", exp_wave.pop_front(), out_wave);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence from the data file

  initial begin
    int fd, code, cnt, gap, num;
    logic [63:0] tag, arg;
    logic [8*256-1:0] rest;
    frame_t f;
    ch_t c, l;
    ch_group_t g;
    sample_t v, l0, l1, l2, l3;
    in_valid = 1'b0;
    in_frame = '0;
    in_ch = '0;
    in_group = '0;
    in_value = '0;
    ready_mode = 2'd0;
    measure = 1'b0;
    fd = $fopen("tb/spk_pack_testdata.txt", "r");
    if (fd == 0) fail_now("cannot open the test data file");
    cnt = 0;
    while (rst !== 1'b0) begin
      @(negedge clk);
      cnt++;
      if (cnt > 10) fail_now("reset never released");
    end
    repeat (3) begin   // quiet before any sample
      @(negedge clk);
      check_flag("out_valid", 1'b0, out_valid);
      check_flag("overflow", 1'b0, overflow);
    end
    code = $fscanf(fd, " %s", tag);
    while (code == 1) begin
      case (tag)
        "#": code = $fgets(rest, fd);   // comment line
        "S": begin
          code = $fscanf(fd, "%h %h %h %h %d", f, c, g, v, gap);
          drive_sample(f, c, g, v, gap);
        end
        "E": begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h", c, l, f, l0, l1, l2, l3);
          push_expected(c, l, f, {l0, l1, l2, l3});
        end
        "B": begin
          code = $fscanf(fd, "%d %h %h %h", num, f, c, v);
          for (int i = 0; i < num; i++) drive_sample(f, c + ch_t'(i), '0, v + i, 0);
        end
        "Q": begin
          code = $fscanf(fd, "%d %h %h %h", num, f, c, v);
          for (int i = 0; i < num; i++) push_expected(c + ch_t'(i), '0, f, {4{v}});
        end
        "M": begin
          code = $fscanf(fd, " %s", arg);
          idle_cycle();
          ready_mode = (arg == "RAND") ? 2'd1 : (arg == "HOLD") ? 2'd2 : 2'd0;
        end
        "W": begin
          idle_cycle();
          wait_drain();
        end
        "V": begin
          code = $fscanf(fd, "%d", num);
          idle_cycle();
          wait_overflow(num != 0);
        end
        "L": measure = 1'b1;
        default: fail_now("unknown line tag in the test data file");
      endcase
      code = $fscanf(fd, " %s", tag);
    end
    $fclose(fd);
    idle_cycle();
    wait_drain();
    repeat (5) idle_cycle();   // nothing extra may follow
    check_flag("out_valid", 1'b0, out_valid);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/spk_pack_pkg.sv
hw/spk_pack_ifs.sv
hw/sample_input_pipe.sv
hw/frame_bank_buffer.sv
hw/record_fifo.sv
hw/spk_pack_top.sv
tb/clk_gen.sv
tb/spk_pack_asserts.sv
tb/spk_pack_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the channel packer simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module spk_pack_tb -o spk_pack_sim

# the simulator exits non-zero on a fatal check, the log decides
./obj_dir/spk_pack_sim 2>&1 | tee sim.log || true

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "RESULT: PASS" sim.log

// ==== tb/spk_pack_testdata.txt ====
# S frame ch group value gap : hex fields, gap in idle cycles (decimal)
# E ch last_ch frame lane0 lane1 lane2 lane3 : hex, lane0 is the top word
# B count frame ch value : back-to-back samples, group 0, ch and value count up
# Q count frame ch lane : expected records, last_ch 0, all lanes equal, ch counts up
# M RAND/HOLD/FREE ready mode, W drain, V overflow level, L measure latency
M RAND
V 0
S 0 005 03020100 00000011 3
E 005 003 0 0 0 0 0
S 0 001 c8a00201 00000022 2
E 001 0c8 0 0 0 0 0
S 0 002 00000000 fffffff0 2
E 002 000 0 0 0 0 0
S 1 007 05020100 00000033 2
E 007 005 1 00000000 00000022 fffffff0 00000011
S 1 001 a0050201 00000044 2
E 001 0a0 1 00000022 fffffff0 00000011 00000000
S 2 003 07090107 00000055 2
E 003 007 2 00000033 00000044 00000000 00000033
S 2 001 9f010701 00000066 2
E 001 09f 2 00000044 00000033 00000044 00000000
W
V 0
M FREE
L
S 3 000 00000000 00000077 2
E 000 000 3 0 0 0 0
W
M HOLD
Q 16 4 010 00000077
B 19 4 010 00000100
V 1
M FREE
W
V 1
